/* verilog/rv_pkg.sv */
// RV32 back end shared types, opcodes, latencies and sizes.
package rv_pkg;

	localparam int XLEN  = 32;
	localparam int NREGS = 32;

	// Issue to write-back pulse, in cycles.
	localparam int LAT_ALU = 2;
	localparam int LAT_MEM = 3;
	localparam int LAT_MUL = 5;

	localparam int MUL_STAGES = 3;

	localparam int DMEM_WORDS = 256;
	localparam int DMEM_AW    = $clog2(DMEM_WORDS);

	// Bit positions in the exception word.
	localparam int EXC_ILLEGAL     = 2;
	localparam int EXC_LD_MISALIGN = 4;
	localparam int EXC_ST_MISALIGN = 6;

	localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		JAL    = 7'b1101111,
		BRANCH = 7'b1100011,
		SYSTEM = 7'b1110011,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011
	} opcode_e;

	typedef enum logic [3:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,
		SLL,
		SRL,
		PASS_B,
		LINK
	} alu_op_e;

	typedef enum logic [1:0] {
		UNIT_ALU,
		UNIT_MUL,
		UNIT_MEM
	} unit_e;

endpackage

/* verilog/wb_if.sv */
// Write-back bundle for one retiring result from an execution unit.
`timescale 1ns/10ps

interface wb_if import rv_pkg::*; ();

	logic            valid;
	logic [XLEN-1:0] data;
	logic [4:0]      rd;
	logic            we;
	logic [XLEN-1:0] exc;
	logic [XLEN-1:0] miss_addr;
	logic [XLEN-1:0] instr;
	logic [XLEN-1:0] pc;

	modport src (
		output valid, data, rd, we, exc, miss_addr, instr, pc
	);

	modport snk (
		input valid, data, rd, we, exc, miss_addr, instr, pc
	);

endinterface

/* verilog/issue_unit.sv */
// Issue stage with decode, scoreboard, write-back slot booking and operand register.
`timescale 1ns/10ps

module issue_unit import rv_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            kill_i,
	input  logic            issue_valid_i,
	input  logic [XLEN-1:0] issue_instr_i,
	input  logic [XLEN-1:0] issue_pc_i,
	output logic            issue_ready_o,
	output logic [4:0]      rf_raddr1_o,
	output logic [4:0]      rf_raddr2_o,
	input  logic [XLEN-1:0] rf_rdata1_i,
	input  logic [XLEN-1:0] rf_rdata2_i,
	input  logic            retire_valid_i,
	input  logic [4:0]      retire_rd_i,
	output logic            alu_valid_o,
	output logic            mul_valid_o,
	output logic            mem_valid_o,
	output logic [XLEN-1:0] op_a_o,
	output logic [XLEN-1:0] op_b_o,
	output logic [XLEN-1:0] store_data_o,
	output alu_op_e         alu_op_o,
	output logic [4:0]      rd_o,
	output logic            we_o,
	output logic [XLEN-1:0] instr_o,
	output logic [XLEN-1:0] pc_o
);

	opcode_e         opcode;
	logic [4:0]      rs1, rs2, rd;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i, imm_s, imm_u;
	unit_e           unit;
	alu_op_e         alu_op;
	logic            use_rs1, use_rs2, writes;
	logic [XLEN-1:0] op_a, op_b;
	logic [4:0]      dst_rd;
	logic [2:0]      lat;
	logic [NREGS-1:0] scoreboard, pending, retire_mask, set_mask;
	logic [LAT_MUL-1:0] slots, slot_mask;
	logic            hazard, slot_busy, accept;

	function automatic alu_op_e f3_op(input logic [2:0] f3, input logic sub);
		case (f3)
			3'b000:  return sub ? SUB : ADD;
			3'b001:  return SLL;
			3'b010:  return SLT;
			3'b100:  return XOR;
			3'b101:  return SRL;
			3'b110:  return OR;
			3'b111:  return AND;
			default: return ADD;
		endcase
	endfunction

	assign opcode = opcode_e'(issue_instr_i[6:0]);
	assign rd     = issue_instr_i[11:7];
	assign funct3 = issue_instr_i[14:12];
	assign rs1    = issue_instr_i[19:15];
	assign rs2    = issue_instr_i[24:20];
	assign funct7 = issue_instr_i[31:25];
	assign imm_i  = {{20{issue_instr_i[31]}}, issue_instr_i[31:20]};
	assign imm_s  = {{20{issue_instr_i[31]}}, issue_instr_i[31:25], issue_instr_i[11:7]};
	assign imm_u  = {issue_instr_i[31:12], 12'b0};

	assign rf_raddr1_o = rs1;
	assign rf_raddr2_o = rs2;

	always_comb begin
		unit    = UNIT_ALU;
		alu_op  = ADD;
		use_rs1 = 1'b0;
		use_rs2 = 1'b0;
		writes  = 1'b0;
		op_a    = rf_rdata1_i;
		op_b    = rf_rdata2_i;
		case (opcode)
			OP: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				writes  = 1'b1;
				if (funct7 == FUNCT7_MULDIV)
					unit = UNIT_MUL;
				else
					alu_op = f3_op(funct3, funct7[5]);
			end
			OP_IMM: begin
				use_rs1 = 1'b1;
				writes  = 1'b1;
				op_b    = imm_i;
				alu_op  = f3_op(funct3, 1'b0);
			end
			LUI: begin
				writes = 1'b1;
				op_b   = imm_u;
				alu_op = PASS_B;
			end
			JAL: begin
				writes = 1'b1;
				alu_op = LINK;
			end
			BRANCH: begin
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
			end
			LOAD: begin
				unit    = UNIT_MEM;
				use_rs1 = 1'b1;
				writes  = 1'b1;
				op_a    = rf_rdata1_i + imm_i;
			end
			STORE: begin
				unit    = UNIT_MEM;
				use_rs1 = 1'b1;
				use_rs2 = 1'b1;
				op_a    = rf_rdata1_i + imm_s;
			end
			// SYSTEM and unknown opcodes go to the ALU without a write.
			default: ;
		endcase
	end

	assign dst_rd = writes ? rd : 5'd0;

	always_comb begin
		case (unit)
			UNIT_MUL: lat = 3'(LAT_MUL);
			UNIT_MEM: lat = 3'(LAT_MEM);
			default:  lat = 3'(LAT_ALU);
		endcase
	end

	// A register retiring this cycle is already free because the register file forwards it.
	assign retire_mask = retire_valid_i ? (NREGS'(1) << retire_rd_i) : '0;
	assign pending     = scoreboard & ~retire_mask;

	assign hazard = (use_rs1 && pending[rs1]) || (use_rs2 && pending[rs2]) || pending[dst_rd];

	// Bit n marks the latch as taken n edges from now.
	assign slot_busy = |(slots & (LAT_MUL'(1) << lat));

	assign issue_ready_o = !kill_i && !hazard && !slot_busy;
	assign accept        = issue_valid_i && issue_ready_o;

	assign set_mask  = (accept && dst_rd != 5'd0) ? (NREGS'(1) << dst_rd) : '0;
	assign slot_mask = accept ? (LAT_MUL'(1) << (lat - 3'd1)) : '0;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			scoreboard  <= '0;
			slots       <= '0;
			alu_valid_o <= 1'b0;
			mul_valid_o <= 1'b0;
			mem_valid_o <= 1'b0;
		end else if (kill_i) begin
			scoreboard  <= '0;
			slots       <= '0;
			alu_valid_o <= 1'b0;
			mul_valid_o <= 1'b0;
			mem_valid_o <= 1'b0;
		end else begin
			scoreboard  <= pending | set_mask;
			slots       <= (slots >> 1) | slot_mask;
			alu_valid_o <= accept && unit == UNIT_ALU;
			mul_valid_o <= accept && unit == UNIT_MUL;
			mem_valid_o <= accept && unit == UNIT_MEM;
		end
	end

	always_ff @(posedge clk_i) begin
		if (accept) begin
			op_a_o       <= op_a;
			op_b_o       <= op_b;
			store_data_o <= rf_rdata2_i;
			alu_op_o     <= alu_op;
			rd_o         <= dst_rd;
			we_o         <= writes;
			instr_o      <= issue_instr_i;
			pc_o         <= issue_pc_i;
		end
	end

endmodule

/* verilog/alu_exec.sv */
// Combinational integer ALU with link, upper immediate and illegal opcode detection.
`timescale 1ns/10ps

module alu_exec import rv_pkg::*; (
	input  logic            alu_valid_i,
	input  logic [XLEN-1:0] op_a_i,
	input  logic [XLEN-1:0] op_b_i,
	input  alu_op_e         alu_op_i,
	input  logic [4:0]      rd_i,
	input  logic            we_i,
	input  logic [XLEN-1:0] instr_i,
	input  logic [XLEN-1:0] pc_i,
	wb_if.src               alu_wb
);

	logic [XLEN-1:0] result;
	logic            illegal;
	logic            no_write;

	always_comb begin
		case (alu_op_i)
			ADD:     result = op_a_i + op_b_i;
			SUB:     result = op_a_i - op_b_i;
			AND:     result = op_a_i & op_b_i;
			OR:      result = op_a_i | op_b_i;
			XOR:     result = op_a_i ^ op_b_i;
			SLT:     result = {{(XLEN-1){1'b0}}, $signed(op_a_i) < $signed(op_b_i)};
			SLL:     result = op_a_i << op_b_i[4:0];
			SRL:     result = op_a_i >> op_b_i[4:0];
			PASS_B:  result = op_b_i;
			LINK:    result = pc_i + XLEN'(4);
			default: result = '0;
		endcase
	end

	// Only the opcodes routed to this unit are legal here.
	always_comb begin
		illegal  = 1'b0;
		no_write = 1'b0;
		case (opcode_e'(instr_i[6:0]))
			OP, OP_IMM, LUI, JAL: ;
			BRANCH, SYSTEM:       no_write = 1'b1;
			default: begin
				illegal  = 1'b1;
				no_write = 1'b1;
			end
		endcase
	end

	assign alu_wb.valid     = alu_valid_i;
	assign alu_wb.data      = result;
	assign alu_wb.rd        = rd_i;
	assign alu_wb.we        = we_i && !no_write;
	assign alu_wb.exc       = illegal ? (XLEN'(1) << EXC_ILLEGAL) : '0;
	assign alu_wb.miss_addr = '0;
	assign alu_wb.instr     = instr_i;
	assign alu_wb.pc        = pc_i;

endmodule

/* verilog/mul_pipe.sv */
// Pipelined 32-bit multiplier returning the low word of the product.
`timescale 1ns/10ps

module mul_pipe import rv_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            kill_i,
	input  logic            mul_valid_i,
	input  logic [XLEN-1:0] op_a_i,
	input  logic [XLEN-1:0] op_b_i,
	input  logic [4:0]      rd_i,
	input  logic [XLEN-1:0] instr_i,
	input  logic [XLEN-1:0] pc_i,
	wb_if.src               mul_wb
);

	logic [MUL_STAGES-1:0] vld_q;
	logic [XLEN-1:0]       pp_lo_q;
	logic [15:0]           pp_hi_q;
	logic [XLEN-1:0]       prod_q  [1:MUL_STAGES-1];
	logic [4:0]            rd_q    [MUL_STAGES];
	logic [XLEN-1:0]       instr_q [MUL_STAGES];
	logic [XLEN-1:0]       pc_q    [MUL_STAGES];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			vld_q <= '0;
		else if (kill_i)
			vld_q <= '0;
		else
			vld_q <= {vld_q[MUL_STAGES-2:0], mul_valid_i};
	end

	always_ff @(posedge clk_i) begin
		// Partial products, upper half needs only its low 16 bits.
		pp_lo_q    <= op_a_i * {16'b0, op_b_i[15:0]};
		pp_hi_q    <= op_a_i[15:0] * op_b_i[31:16];
		rd_q[0]    <= rd_i;
		instr_q[0] <= instr_i;
		pc_q[0]    <= pc_i;

		prod_q[1] <= pp_lo_q + {pp_hi_q, 16'b0};
		for (int s = 2; s < MUL_STAGES; s++)
			prod_q[s] <= prod_q[s-1];

		for (int s = 1; s < MUL_STAGES; s++) begin
			rd_q[s]    <= rd_q[s-1];
			instr_q[s] <= instr_q[s-1];
			pc_q[s]    <= pc_q[s-1];
		end
	end

	assign mul_wb.valid     = vld_q[MUL_STAGES-1];
	assign mul_wb.data      = prod_q[MUL_STAGES-1];
	assign mul_wb.rd        = rd_q[MUL_STAGES-1];
	assign mul_wb.we        = 1'b1;
	assign mul_wb.exc       = '0;
	assign mul_wb.miss_addr = '0;
	assign mul_wb.instr     = instr_q[MUL_STAGES-1];
	assign mul_wb.pc        = pc_q[MUL_STAGES-1];

endmodule

/* verilog/mem_stage.sv */
// Data memory stage with word loads, word stores and alignment checks.
`timescale 1ns/10ps

module mem_stage import rv_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            kill_i,
	input  logic            mem_valid_i,
	input  logic [XLEN-1:0] addr_i,
	input  logic [XLEN-1:0] store_data_i,
	input  logic [4:0]      rd_i,
	input  logic [XLEN-1:0] instr_i,
	input  logic [XLEN-1:0] pc_i,
	wb_if.src               mem_wb
);

	logic [XLEN-1:0]    mem [DMEM_WORDS];
	logic [DMEM_AW-1:0] idx;
	logic               is_store;
	logic               misalign;
	logic               wr_en;

	logic               vld_q;
	logic [XLEN-1:0]    rdata_q;
	logic [4:0]         rd_q;
	logic               we_q;
	logic [XLEN-1:0]    exc_q;
	logic [XLEN-1:0]    miss_q;
	logic [XLEN-1:0]    instr_q;
	logic [XLEN-1:0]    pc_q;

	assign idx      = addr_i[DMEM_AW+1:2];
	assign is_store = instr_i[6:0] == STORE;
	assign misalign = addr_i[1:0] != 2'b00;
	// Stores already issued complete even under kill.
	assign wr_en    = mem_valid_i && is_store && !misalign;

	always_ff @(posedge clk_i) begin
		if (wr_en)
			mem[idx] <= store_data_i;
		if (mem_valid_i) begin
			rdata_q <= mem[idx];
			rd_q    <= rd_i;
			we_q    <= !is_store && !misalign;
			instr_q <= instr_i;
			pc_q    <= pc_i;
			miss_q  <= misalign ? addr_i : '0;
			if (!misalign)
				exc_q <= '0;
			else if (is_store)
				exc_q <= XLEN'(1) << EXC_ST_MISALIGN;
			else
				exc_q <= XLEN'(1) << EXC_LD_MISALIGN;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i)
			vld_q <= 1'b0;
		else
			vld_q <= mem_valid_i && !kill_i;
	end

	assign mem_wb.valid     = vld_q;
	assign mem_wb.data      = rdata_q;
	assign mem_wb.rd        = rd_q;
	assign mem_wb.we        = we_q;
	assign mem_wb.exc       = exc_q;
	assign mem_wb.miss_addr = miss_q;
	assign mem_wb.instr     = instr_q;
	assign mem_wb.pc        = pc_q;

endmodule

/* verilog/exe_write_latch.sv */
// Priority register between the execution units and register write back.
`timescale 1ns/10ps

module exe_write_latch import rv_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            kill_i,
	wb_if.snk               exe_wb,
	wb_if.snk               mult_wb,
	wb_if.snk               cache_wb,
	output logic            wb_valid_o,
	output logic [XLEN-1:0] wb_data_o,
	output logic [4:0]      wb_rd_o,
	output logic            wb_we_o,
	output logic [XLEN-1:0] wb_exc_o,
	output logic [XLEN-1:0] wb_miss_addr_o,
	output logic [XLEN-1:0] wb_instr_o,
	output logic [XLEN-1:0] wb_pc_o
);

	logic            nxt_valid;
	logic            nxt_we;
	logic [XLEN-1:0] nxt_data;
	logic [4:0]      nxt_rd;
	logic [XLEN-1:0] nxt_exc;
	logic [XLEN-1:0] nxt_miss;
	logic [XLEN-1:0] nxt_instr;
	logic [XLEN-1:0] nxt_pc;

	// Multiplier first, then memory, then ALU.
	always_comb begin
		nxt_valid = 1'b1;
		if (mult_wb.valid) begin
			nxt_we    = mult_wb.we;
			nxt_data  = mult_wb.data;
			nxt_rd    = mult_wb.rd;
			nxt_exc   = mult_wb.exc;
			nxt_miss  = mult_wb.miss_addr;
			nxt_instr = mult_wb.instr;
			nxt_pc    = mult_wb.pc;
		end else if (cache_wb.valid) begin
			nxt_we    = cache_wb.we;
			nxt_data  = cache_wb.data;
			nxt_rd    = cache_wb.rd;
			nxt_exc   = cache_wb.exc;
			nxt_miss  = cache_wb.miss_addr;
			nxt_instr = cache_wb.instr;
			nxt_pc    = cache_wb.pc;
		end else begin
			nxt_valid = exe_wb.valid;
			nxt_we    = exe_wb.we;
			nxt_data  = exe_wb.data;
			nxt_rd    = exe_wb.rd;
			nxt_exc   = exe_wb.exc;
			nxt_miss  = exe_wb.miss_addr;
			nxt_instr = exe_wb.instr;
			nxt_pc    = exe_wb.pc;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wb_valid_o <= 1'b0;
			wb_we_o    <= 1'b0;
		end else if (kill_i) begin
			wb_valid_o <= 1'b0;
			wb_we_o    <= 1'b0;
		end else begin
			wb_valid_o <= nxt_valid;
			wb_we_o    <= nxt_valid && nxt_we;
		end
	end

	always_ff @(posedge clk_i) begin
		if (nxt_valid) begin
			wb_data_o      <= nxt_data;
			wb_rd_o        <= nxt_rd;
			wb_exc_o       <= nxt_exc;
			wb_miss_addr_o <= nxt_miss;
			wb_instr_o     <= nxt_instr;
			wb_pc_o        <= nxt_pc;
		end
	end

endmodule

/* verilog/regfile.sv */
// Integer register file, two read ports and one write port with forwarding.
`timescale 1ns/10ps

module regfile import rv_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic [4:0]      raddr1_i,
	input  logic [4:0]      raddr2_i,
	output logic [XLEN-1:0] rdata1_o,
	output logic [XLEN-1:0] rdata2_o,
	input  logic            we_i,
	input  logic [4:0]      waddr_i,
	input  logic [XLEN-1:0] wdata_i
);

	logic [XLEN-1:0] regs [NREGS];

	function automatic logic [XLEN-1:0] read_port(input logic [4:0] addr);
		if (addr == 5'd0)
			return '0;
		else if (we_i && waddr_i == addr)
			return wdata_i;
		else
			return regs[addr];
	endfunction

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			for (int i = 0; i < NREGS; i++)
				regs[i] <= '0;
		end else if (we_i && waddr_i != 5'd0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = read_port(raddr1_i);
	assign rdata2_o = read_port(raddr2_i);

endmodule

/* verilog/backend_top.sv */
// RV32 back end top level joining issue, execution units, write back and registers.
`timescale 1ns/10ps

module backend_top import rv_pkg::*; (
	input  logic            clk_i,
	input  logic            rst_n_i,
	input  logic            kill_i,
	input  logic            issue_valid_i,
	input  logic [XLEN-1:0] issue_instr_i,
	input  logic [XLEN-1:0] issue_pc_i,
	output logic            issue_ready_o,
	output logic            wb_valid_o,
	output logic [XLEN-1:0] wb_data_o,
	output logic [4:0]      wb_rd_o,
	output logic            wb_we_o,
	output logic [XLEN-1:0] wb_exc_o,
	output logic [XLEN-1:0] wb_miss_addr_o,
	output logic [XLEN-1:0] wb_instr_o,
	output logic [XLEN-1:0] wb_pc_o
);

	logic [4:0]      rf_raddr1, rf_raddr2;
	logic [XLEN-1:0] rf_rdata1, rf_rdata2;
	logic            rf_we;
	logic            alu_valid, mul_valid, mem_valid;
	logic [XLEN-1:0] op_a, op_b, store_data;
	alu_op_e         alu_op;
	logic [4:0]      rd;
	logic            we;
	logic [XLEN-1:0] instr, pc;

	wb_if alu_wb ();
	wb_if mul_wb ();
	wb_if mem_wb ();

	issue_unit u_issue (
		.clk_i, .rst_n_i, .kill_i,
		.issue_valid_i, .issue_instr_i, .issue_pc_i, .issue_ready_o,
		.rf_raddr1_o (rf_raddr1), .rf_raddr2_o (rf_raddr2),
		.rf_rdata1_i (rf_rdata1), .rf_rdata2_i (rf_rdata2),
		.retire_valid_i (wb_valid_o), .retire_rd_i (wb_rd_o),
		.alu_valid_o (alu_valid), .mul_valid_o (mul_valid), .mem_valid_o (mem_valid),
		.op_a_o (op_a), .op_b_o (op_b), .store_data_o (store_data),
		.alu_op_o (alu_op), .rd_o (rd), .we_o (we), .instr_o (instr), .pc_o (pc)
	);

	alu_exec u_alu (
		.alu_valid_i (alu_valid), .op_a_i (op_a), .op_b_i (op_b), .alu_op_i (alu_op),
		.rd_i (rd), .we_i (we), .instr_i (instr), .pc_i (pc), .alu_wb (alu_wb)
	);

	mul_pipe u_mul (
		.clk_i, .rst_n_i, .kill_i, .mul_valid_i (mul_valid),
		.op_a_i (op_a), .op_b_i (op_b), .rd_i (rd), .instr_i (instr), .pc_i (pc),
		.mul_wb (mul_wb)
	);

	mem_stage u_mem (
		.clk_i, .rst_n_i, .kill_i, .mem_valid_i (mem_valid),
		.addr_i (op_a), .store_data_i (store_data), .rd_i (rd), .instr_i (instr),
		.pc_i (pc), .mem_wb (mem_wb)
	);

	exe_write_latch u_latch (
		.clk_i, .rst_n_i, .kill_i,
		.exe_wb (alu_wb), .mult_wb (mul_wb), .cache_wb (mem_wb),
		.wb_valid_o, .wb_data_o, .wb_rd_o, .wb_we_o, .wb_exc_o, .wb_miss_addr_o,
		.wb_instr_o, .wb_pc_o
	);

	// Faulting results never reach the register file.
	assign rf_we = wb_valid_o && wb_we_o && wb_exc_o == '0 && wb_rd_o != 5'd0;

	regfile u_rf (
		.clk_i, .rst_n_i,
		.raddr1_i (rf_raddr1), .raddr2_i (rf_raddr2),
		.rdata1_o (rf_rdata1), .rdata2_o (rf_rdata2),
		.we_i (rf_we), .waddr_i (wb_rd_o), .wdata_i (wb_data_o)
	);

endmodule

/* dv/backend_props.sv */
// Write-back and kill properties for the back end top level and its latch.
`timescale 1ns/10ps

module backend_props (
	input logic clk_i,
	input logic rst_n_i,
	input logic kill_i,
	input logic src_a_i,
	input logic src_b_i,
	input logic src_c_i,
	input logic out_valid_i
);

	int fail_count = 0;

	// Slot booking keeps the three sources apart.
	one_source_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0({src_a_i, src_b_i, src_c_i}))
		else begin $error("more than one unit valid at the latch"); fail_count++; end

	kill_flush_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		kill_i |=> !out_valid_i)
		else begin $error("write back valid in the cycle after kill"); fail_count++; end

	retire_source_a: assert property (@(posedge clk_i) disable iff (!rst_n_i)
		out_valid_i |-> $past(src_a_i || src_b_i || src_c_i))
		else begin $error("write back valid without a unit result"); fail_count++; end

endmodule

bind backend_top backend_props u_props (
	.clk_i (clk_i), .rst_n_i (rst_n_i), .kill_i (kill_i),
	.src_a_i (alu_wb.valid), .src_b_i (mul_wb.valid), .src_c_i (mem_wb.valid),
	.out_valid_i (wb_valid_o)
);

bind exe_write_latch backend_props u_props (
	.clk_i (clk_i), .rst_n_i (rst_n_i), .kill_i (kill_i),
	.src_a_i (exe_wb.valid), .src_b_i (mult_wb.valid), .src_c_i (cache_wb.valid),
	.out_valid_i (wb_valid_o)
);

/* dv/backend_tb.sv */
// Testbench for the RV32 back end with a shadow register and memory model.
`timescale 1ns/10ps

module backend_tb import rv_pkg::*; ();

	localparam int CYCLE_LIMIT = 5 * 200 * 2;

	logic clk_i, rst_n_i, kill_i, issue_valid_i, issue_ready_o;
	logic [31:0] issue_instr_i, issue_pc_i;
	logic wb_valid_o, wb_we_o;
	logic [4:0] wb_rd_o;
	logic [31:0] wb_data_o, wb_exc_o, wb_miss_addr_o, wb_instr_o, wb_pc_o;

	integer seed = 52;
	int cycles = 0, errors = 0, checks = 0, stalls = 0, mark;
	logic [31:0] pc = 32'h100;
	logic [31:0] shadow_regs [32], commit_regs [32];
	logic [31:0] shadow_mem [int];
	logic [31:0] exp_data [logic [31:0]], exp_exc [logic [31:0]], exp_miss [logic [31:0]];
	logic [31:0] exp_instr [logic [31:0]];
	logic        exp_we [logic [31:0]];
	logic [4:0]  exp_rd [logic [31:0]];
	int          exp_cyc [logic [31:0]], exp_lat [logic [31:0]];

	backend_top u_dut (.*);

	initial begin
		clk_i = 1'b0;
		forever #5 clk_i = ~clk_i;
	end

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("TB FAILED");
			$finish;
		end
	end

	function automatic logic [31:0] calc_alu(input logic [2:0] f3, input logic sub,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'b000:  return sub ? a - b : a + b;
			3'b001:  return a << b[4:0];
			3'b010:  return {31'b0, $signed(a) < $signed(b)};
			3'b100:  return a ^ b;
			3'b101:  return a >> b[4:0];
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic logic [31:0] enc_sw(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
	endfunction

	// Expected retirement of one accepted instruction, by the ISA rules.
	task automatic predict(input logic [31:0] ins, input logic [31:0] p);
		logic [31:0] a, b, res, addr, exc, miss, imm;
		logic        we;
		int          lat;
		a = shadow_regs[ins[19:15]];
		b = shadow_regs[ins[24:20]];
		imm = {{20{ins[31]}}, ins[31:20]};
		res = '0;
		exc = '0;
		miss = '0;
		we = 1'b0;
		lat = LAT_ALU;
		case (ins[6:0])
			OP: begin
				we = 1'b1;
				if (ins[31:25] == 7'd1) begin
					res = a * b;
					lat = LAT_MUL;
				end else
					res = calc_alu(ins[14:12], ins[30], a, b);
			end
			OP_IMM: begin
				we = 1'b1;
				res = calc_alu(ins[14:12], 1'b0, a, imm);
			end
			LUI: begin
				we = 1'b1;
				res = {ins[31:12], 12'b0};
			end
			JAL: begin
				we = 1'b1;
				res = p + 32'd4;
			end
			BRANCH, SYSTEM: ;
			LOAD: begin
				lat = LAT_MEM;
				addr = a + imm;
				if (addr[1:0] != 2'b00) begin
					exc = 32'd1 << EXC_LD_MISALIGN;
					miss = addr;
				end else begin
					we = 1'b1;
					res = shadow_mem[int'(addr[9:2])];
				end
			end
			STORE: begin
				lat = LAT_MEM;
				addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
				if (addr[1:0] != 2'b00) begin
					exc = 32'd1 << EXC_ST_MISALIGN;
					miss = addr;
				end else
					shadow_mem[int'(addr[9:2])] = b;
			end
			default: exc = 32'd1 << EXC_ILLEGAL;
		endcase
		if (we && ins[11:7] != 5'd0)
			shadow_regs[ins[11:7]] = res;
		exp_data[p] = res;
		exp_we[p] = we;
		exp_exc[p] = exc;
		exp_miss[p] = miss;
		exp_instr[p] = ins;
		exp_rd[p] = ins[11:7];
		exp_cyc[p] = cycles;
		exp_lat[p] = lat;
	endtask

	// Called 1 ns after a rising edge; returns 1 ns after the accepting edge.
	task automatic issue(input logic [31:0] ins);
		logic done;
		done = 1'b0;
		issue_valid_i = 1'b1;
		issue_instr_i = ins;
		issue_pc_i = pc;
		while (!done) begin
			@(negedge clk_i);
			if (issue_ready_o) begin
				predict(ins, pc);
				done = 1'b1;
			end else
				stalls++;
			@(posedge clk_i);
			#1;
		end
		issue_valid_i = 1'b0;
		pc = pc + 32'd4;
	endtask

	always @(negedge clk_i) begin
		if (rst_n_i && wb_valid_o) begin
			checks++;
			if (!exp_we.exists(wb_pc_o)) begin
				$display("Retire of pc %h that is not in flight at %0t", wb_pc_o, $time);
				errors++;
			end else begin
				assert (wb_we_o == exp_we[wb_pc_o] && wb_exc_o == exp_exc[wb_pc_o] &&
						wb_miss_addr_o == exp_miss[wb_pc_o] &&
						wb_instr_o == exp_instr[wb_pc_o] && (!exp_we[wb_pc_o] ||
						(wb_data_o == exp_data[wb_pc_o] && wb_rd_o == exp_rd[wb_pc_o])))
				else begin
					$display("Fail at %0t: pc %h instr %h data %h we %b exc %h, expected %h %h %b %h",
						$time, wb_pc_o, wb_instr_o, wb_data_o, wb_we_o, wb_exc_o,
						exp_instr[wb_pc_o], exp_data[wb_pc_o], exp_we[wb_pc_o],
						exp_exc[wb_pc_o]);
					errors++;
				end
				assert (cycles - exp_cyc[wb_pc_o] == exp_lat[wb_pc_o])
				else begin
					$display("Fail at %0t: pc %h retired after %0d cycles, expected %0d",
						$time, wb_pc_o, cycles - exp_cyc[wb_pc_o], exp_lat[wb_pc_o]);
					errors++;
				end
				if (exp_we[wb_pc_o] && exp_exc[wb_pc_o] == '0 && exp_rd[wb_pc_o] != 5'd0)
					commit_regs[exp_rd[wb_pc_o]] = exp_data[wb_pc_o];
				exp_data.delete(wb_pc_o);
				exp_we.delete(wb_pc_o);
				exp_exc.delete(wb_pc_o);
				exp_miss.delete(wb_pc_o);
				exp_instr.delete(wb_pc_o);
				exp_rd.delete(wb_pc_o);
				exp_cyc.delete(wb_pc_o);
				exp_lat.delete(wb_pc_o);
			end
		end
	end

	task automatic drain();
		while (exp_we.size() != 0)
			@(posedge clk_i);
		#1;
	endtask

	task automatic report_test(input string name, input int err_before);
		drain();
		$display("%s: %0d errors", name, errors - err_before);
	endtask

	task automatic random_alu(input int count);
		logic [2:0] f3;
		logic [11:0] imm;
		int kind;
		for (int i = 0; i < count; i++) begin
			kind = $unsigned($random(seed)) % 4;
			f3 = $random(seed);
			f3 = (f3 == 3'b011) ? 3'b000 : f3;
			imm = $random(seed);
			if (f3 == 3'b001 || f3 == 3'b101)
				imm = {7'b0, imm[4:0]};
			case (kind)
				0: issue(enc_r((f3 == 3'b000) ? {1'b0, imm[0], 5'b0} : 7'b0, $random(seed) % 8,
					$unsigned($random(seed)) % 8, f3, $unsigned($random(seed)) % 8));
				1: issue(enc_i(imm, $unsigned($random(seed)) % 8, f3,
					$unsigned($random(seed)) % 8, OP_IMM));
				2: issue({20'($random(seed)), 5'($unsigned($random(seed)) % 8), 7'(LUI)});
				default: issue({20'b0, 5'($unsigned($random(seed)) % 8), 7'(JAL)});
			endcase
		end
	endtask

	initial begin
		rst_n_i = 1'b0;
		kill_i = 1'b0;
		issue_valid_i = 1'b0;
		issue_instr_i = '0;
		issue_pc_i = '0;
		for (int r = 0; r < 32; r++) begin
			shadow_regs[r] = '0;
			commit_regs[r] = '0;
		end
		repeat (8) @(posedge clk_i);
		#1 rst_n_i = 1'b1;

		mark = errors;
		random_alu(60);
		issue(enc_i(12'h123, 5'd0, 3'b000, 5'd0, OP_IMM));
		issue(enc_r(7'b0, 5'd0, 5'd0, 3'b000, 5'd1));
		report_test("alu sequences", mark);

		mark = errors;
		issue(enc_r(7'd1, 5'd2, 5'd1, 3'b000, 5'd3));
		issue(enc_r(7'b0, 5'd5, 5'd4, 3'b110, 5'd6));
		issue(enc_i(12'h7ff, 5'd4, 3'b100, 5'd7, OP_IMM));
		issue(enc_r(7'd1, 5'd7, 5'd6, 3'b000, 5'd1));
		report_test("multiply", mark);

		mark = errors;
		issue(enc_i(12'h040, 5'd0, 3'b000, 5'd5, OP_IMM));
		issue({20'($random(seed)), 5'd6, 7'(LUI)});
		issue(enc_i(12'h5a5, 5'd6, 3'b000, 5'd6, OP_IMM));
		issue(enc_sw(12'd0, 5'd6, 5'd5));
		issue(enc_i(12'd0, 5'd5, 3'b010, 5'd7, LOAD));
		issue(enc_sw(12'd2, 5'd5, 5'd5));
		issue(enc_i(12'd1, 5'd5, 3'b010, 5'd8, LOAD));
		issue(enc_i(12'd0, 5'd5, 3'b010, 5'd9, LOAD));
		issue(enc_r(7'b0, 5'd0, 5'd8, 3'b110, 5'd10));
		report_test("load store", mark);

		mark = errors;
		stalls = 0;
		issue(enc_i(12'd5, 5'd0, 3'b000, 5'd1, OP_IMM));
		issue(enc_r(7'b0, 5'd1, 5'd1, 3'b000, 5'd2));
		issue(enc_r(7'd1, 5'd1, 5'd2, 3'b000, 5'd3));
		issue(enc_r(7'b0, 5'd2, 5'd3, 3'b000, 5'd4));
		assert (stalls > 0)
		else begin
			$display("Dependent instructions issued without any stall");
			errors++;
		end
		report_test("hazards", mark);

		mark = errors;
		issue({25'b0, 7'b0001011});
		issue({7'b0, 5'd2, 5'd1, 3'b000, 5'd0, 7'(BRANCH)});
		issue({25'b0, 7'(SYSTEM)});
		report_test("illegal and no write", mark);

		mark = errors;
		issue(enc_i(12'h011, 5'd0, 3'b000, 5'd10, OP_IMM));
		drain();
		issue(enc_r(7'd1, 5'd10, 5'd10, 3'b000, 5'd11));
		issue(enc_r(7'b0, 5'd10, 5'd10, 3'b000, 5'd12));
		kill_i = 1'b1;
		@(posedge clk_i);
		#1 kill_i = 1'b0;
		shadow_regs = commit_regs;
		exp_data.delete();
		exp_we.delete();
		exp_exc.delete();
		exp_miss.delete();
		exp_instr.delete();
		exp_rd.delete();
		exp_cyc.delete();
		exp_lat.delete();
		issue(enc_r(7'b0, 5'd10, 5'd11, 3'b000, 5'd13));
		issue(enc_r(7'd1, 5'd13, 5'd10, 3'b000, 5'd12));
		repeat (8) @(posedge clk_i);
		#1;
		report_test("kill", mark);

		errors = errors + u_dut.u_props.fail_count + u_dut.u_latch.u_props.fail_count;
		$display("retires checked %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

/* project.f */
verilog/rv_pkg.sv
verilog/wb_if.sv
verilog/issue_unit.sv
verilog/alu_exec.sv
verilog/mul_pipe.sv
verilog/mem_stage.sv
verilog/exe_write_latch.sv
verilog/regfile.sv
verilog/backend_top.sv
dv/backend_props.sv
dv/backend_tb.sv

/* Bender.yml */
package:
  name: rv_backend

sources:
  - files:
      - verilog/rv_pkg.sv
      - verilog/wb_if.sv
      - verilog/issue_unit.sv
      - verilog/alu_exec.sv
      - verilog/mul_pipe.sv
      - verilog/mem_stage.sv
      - verilog/exe_write_latch.sv
      - verilog/regfile.sv
      - verilog/backend_top.sv
  - target: test
    files:
      - dv/backend_props.sv
      - dv/backend_tb.sv
